/* common/wm_macros.svh */
/*
 * AXI4 write master shared widths and limits
 * Bus widths, burst geometry, outstanding limit and FIFO depth
 */
`ifndef WM_MACROS_SVH
`define WM_MACROS_SVH

// Bus widths
`define WM_ADDR_WIDTH 32
`define WM_DATA_WIDTH 32

// Byte count of one request
`define WM_XFER_SIZE_WIDTH 20

// Full burst geometry, 256 beats of 4 bytes
`define WM_BURST_LEN 256
`define WM_BURST_BYTES 1024

// Bursts with an address out and no response yet
`define WM_MAX_OUTSTANDING 32

// Stream buffer
`define WM_FIFO_DEPTH 32

`endif

/* common/wm_pkg.sv */
/*
 * AXI4 write master types
 * Vector types for addresses, data and counts, plus the packed structs
 * that carry the request, the derived plan and the AXI payloads
 */
`include "wm_macros.svh"

package wm_pkg;

  typedef logic [`WM_ADDR_WIDTH-1:0]                            addr_t;
  typedef logic [`WM_DATA_WIDTH-1:0]                            data_t;
  typedef logic [`WM_DATA_WIDTH/8-1:0]                          strb_t;
  typedef logic [`WM_XFER_SIZE_WIDTH-1:0]                       xfer_size_t;
  // Beat index in a burst, same encoding as AWLEN
  typedef logic [$clog2(`WM_BURST_LEN)-1:0]                     beat_cnt_t;
  typedef logic [`WM_XFER_SIZE_WIDTH-$clog2(`WM_BURST_BYTES)-1:0] burst_cnt_t;
  typedef logic [$clog2(`WM_MAX_OUTSTANDING+1)-1:0]             credit_t;

  typedef struct packed {
    addr_t      addr;
    xfer_size_t xfer_size;
  } ctrl_req_t;

  // Request after alignment and splitting into bursts
  typedef struct packed {
    addr_t      base_addr;
    burst_cnt_t last_burst;
    beat_cnt_t  final_len;
    strb_t      final_strb;
  } xfer_plan_t;

  typedef struct packed {
    addr_t     addr;
    beat_cnt_t len;
  } aw_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_beat_t;

endpackage

/* project.f */
+incdir+common
+incdir+tests
common/wm_pkg.sv
src/wm_counter.sv
src/wm_request.sv
src/wm_data_fifo.sv
write_channels/wm_w_channel.sv
write_channels/wm_aw_channel.sv
write_channels/wm_b_channel.sv
src/wm_write_master.sv
tests/tb_write_master.sv

/* run.sh */
#!/bin/sh
# Build and run the write master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_write_master -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_write_master)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found"
exit 1

/* src/wm_counter.sv */
`timescale 1ns/1ps
/*
 * Loadable up/down counter with a zero flag
 * Load has priority, otherwise it steps when incr and decr differ
 */
module wm_counter #(
  parameter int               width       = 8,
  parameter logic [width-1:0] reset_value = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= reset_value;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  assign is_zero = (count == '0);

  // Callers must never step below zero
  a_no_underflow : assert property (@(posedge aclk) disable iff (areset)
    (decr && !incr && !load) |-> !is_zero)
    else $error("wm_counter stepped down from zero");

endmodule

/* src/wm_data_fifo.sv */
`timescale 1ns/1ps
/*
 * Stream word buffer
 * Synchronous first-word-fall-through FIFO, circular storage with
 * registered valid and full flags
 */
`include "wm_macros.svh"

module wm_data_fifo (
  input  logic          aclk,
  input  logic          areset,
  input  logic          push,
  input  wm_pkg::data_t push_data,
  output logic          full,
  input  logic          pop,
  output logic          pop_valid,
  output wm_pkg::data_t pop_data
);
  import wm_pkg::*;

  localparam int depth     = `WM_FIFO_DEPTH;
  localparam int ptr_width = $clog2(depth);

  data_t                mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic [ptr_width:0]   count_next;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Head of the queue is always on the output
  assign pop_data = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_valid <= 1'b0;
      full      <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count_next;
      pop_valid <= (count_next != '0);
      full      <= (count_next == depth[ptr_width:0]);
    end
  end

  a_no_overflow : assert property (@(posedge aclk) disable iff (areset) push |-> !full)
    else $error("wm_data_fifo push while full");
  a_no_underflow : assert property (@(posedge aclk) disable iff (areset) pop |-> pop_valid)
    else $error("wm_data_fifo pop while empty");

endmodule

/* src/wm_request.sv */
`timescale 1ns/1ps
/*
 * Request capture for the write master
 * Registers address and byte count, then derives the aligned base,
 * the burst count, the final burst length and the last-beat strobe
 */
`include "wm_macros.svh"

module wm_request (
  input  logic               aclk,
  input  logic               areset,
  input  logic               ctrl_start,
  input  wm_pkg::ctrl_req_t  ctrl_req,
  output wm_pkg::xfer_plan_t plan,
  output logic               start
);
  import wm_pkg::*;

  localparam int    word_bits   = $clog2(`WM_DATA_WIDTH/8);
  localparam int    burst_bits  = $clog2(`WM_BURST_LEN);
  localparam int    beats_width = `WM_XFER_SIZE_WIDTH - word_bits;
  localparam addr_t burst_mask  = addr_t'(`WM_BURST_BYTES - 1);

  logic                   start_d1;
  ctrl_req_t              req_r;
  logic [word_bits-1:0]   byte_rem;
  logic [beats_width-1:0] size_words;
  logic [beats_width-1:0] beats_m1;
  strb_t                  final_strb;

  // Two stage start so the plan is ready with the pulse
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  // Stage 1
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      req_r <= ctrl_req;
    end
  end

  assign byte_rem   = req_r.xfer_size[word_bits-1:0];
  assign size_words = req_r.xfer_size[`WM_XFER_SIZE_WIDTH-1:word_bits];
  // Round up to whole words, in AXI length form
  assign beats_m1   = (byte_rem == '0) ? size_words - 1'b1 : size_words;

  // Low size mod 4 bytes enabled, all of them on a whole word
  always_comb begin
    for (int i = 0; i < $bits(strb_t); i++) begin
      final_strb[i] = (byte_rem == '0) || (i < byte_rem);
    end
  end

  ////////////////////
  // Stage 2
  ////////////////////
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      plan.base_addr  <= req_r.addr & ~burst_mask;
      plan.last_burst <= beats_m1[beats_width-1:burst_bits];
      plan.final_len  <= beats_m1[burst_bits-1:0];
      plan.final_strb <= final_strb;
    end
  end

endmodule

/* src/wm_write_master.sv */
`timescale 1ns/1ps
/*
 * AXI4 write master top level
 * Stream words are buffered, then written as incrementing bursts
 * with address, data and response handled by separate channels
 */
module wm_write_master (
  input  logic              aclk,
  input  logic              areset,
  // Control
  input  logic              ctrl_start,
  input  wm_pkg::ctrl_req_t ctrl_req,
  output logic              ctrl_done,
  // Stream in
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  wm_pkg::data_t     s_axis_tdata,
  // AXI write address
  output logic              m_axi_awvalid,
  input  logic              m_axi_awready,
  output wm_pkg::aw_req_t   m_axi_aw,
  // AXI write data
  output logic              m_axi_wvalid,
  input  logic              m_axi_wready,
  output wm_pkg::w_beat_t   m_axi_w,
  // AXI write response
  input  logic              m_axi_bvalid,
  output logic              m_axi_bready
);
  import wm_pkg::*;

  xfer_plan_t plan;
  logic       start;
  logic       fifo_full;
  logic       fifo_push;
  logic       fifo_valid;
  logic       fifo_pop;
  data_t      fifo_data;

  assign s_axis_tready = ~fifo_full;
  assign fifo_push     = s_axis_tvalid & s_axis_tready;

  wm_request u_request (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .plan       (plan),
    .start      (start)
  );

  wm_data_fifo u_data_fifo (
    .aclk      (aclk),
    .areset    (areset),
    .push      (fifo_push),
    .push_data (s_axis_tdata),
    .full      (fifo_full),
    .pop       (fifo_pop),
    .pop_valid (fifo_valid),
    .pop_data  (fifo_data)
  );

  wm_w_channel u_w_channel (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .fifo_valid   (fifo_valid),
    .fifo_data    (fifo_data),
    .fifo_pop     (fifo_pop),
    .m_axi_wvalid (m_axi_wvalid),
    .m_axi_wready (m_axi_wready),
    .m_axi_w      (m_axi_w)
  );

  wm_aw_channel u_aw_channel (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .plan          (plan),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wlast   (m_axi_w.last),
    .m_axi_wready  (m_axi_wready),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_bvalid  (m_axi_bvalid)
  );

  wm_b_channel u_b_channel (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .ctrl_done    (ctrl_done)
  );

endmodule

/* tests/tb_checks.svh */
/*
 * Testbench helpers for the AXI4 write master
 * Random source, typed compare tasks, stream driver and the directed tests
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Linear congruential step, upper bits are the useful ones
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

////////////////////
// Compare tasks
////////////////////
task automatic check_addr(input string name, input addr_t got, input addr_t exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                        $time, name, got, exp));
  end
endtask

task automatic check_len(input string name, input beat_cnt_t got, input beat_cnt_t exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
  end
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                        $time, name, got, exp));
  end
endtask

task automatic check_strb(input string name, input strb_t got, input strb_t exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
  end
endtask

// Sends exp_data in order, entered on a falling edge
task automatic send_stream(input bit gaps);
  int idle;
  for (int i = 0; i < exp_data.size(); i++) begin
    idle = 0;
    if (gaps) begin
      stream_rand = lcg_next(stream_rand);
      idle = (stream_rand[18:16] < 3'd3) ? int'(stream_rand[21:19]) : 0;
    end
    repeat (idle) @(negedge aclk);
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = exp_data[i];
    // tready only moves on the rising edge
    while (!s_axis_tready) @(negedge aclk);
    @(negedge aclk);
    s_axis_tvalid = 1'b0;
  end
endtask

task automatic wait_done(input int base, input int nwords);
  int cycles_left;
  cycles_left = 20 * nwords + 500;
  while (done_cnt == base) begin
    if (cycles_left == 0) begin
      abort_run($sformatf("ctrl_done did not pulse within %0d cycles", 20 * nwords + 500));
    end
    cycles_left--;
    @(negedge aclk);
  end
endtask

// One request, then every AW and W beat against the burst rules
task automatic run_transfer(input addr_t addr, input xfer_size_t size, input bit gaps);
  ctrl_req_t req;
  aw_req_t   aw;
  w_beat_t   beat;
  strb_t     last_strb;
  int        sz;
  int        nwords;
  int        nbursts;
  int        aw_base;
  int        w_base;
  int        done_base;
  sz        = int'(size);
  nwords    = (sz + 3) / 4;
  nbursts   = (nwords + `WM_BURST_LEN - 1) / `WM_BURST_LEN;
  last_strb = (sz % 4 == 0) ? strb_t'(4'hF) : strb_t'((1 << (sz % 4)) - 1);
  aw_base   = aw_q.size();
  w_base    = w_q.size();
  done_base = done_cnt;
  b_target  = b_cnt + nbursts;
  xfer_cnt++;
  req.addr      = addr;
  req.xfer_size = size;
  @(negedge aclk);
  ctrl_req   = req;
  ctrl_start = 1'b1;
  @(negedge aclk);
  ctrl_start = 1'b0;
  fork
    send_stream(gaps);
    wait_done(done_base, nwords);
  join
  check_count("AW bursts", aw_q.size() - aw_base, nbursts);
  check_count("W beats", w_q.size() - w_base, nwords);
  // Aligned base, one full burst step per address
  for (int j = 0; j < nbursts; j++) begin
    aw = aw_q[aw_base + j];
    check_addr("m_axi_aw.addr", aw.addr,
               (addr & ~addr_t'(`WM_BURST_BYTES - 1)) + addr_t'(j * `WM_BURST_BYTES));
    check_len("m_axi_aw.len", aw.len, (j == nbursts - 1) ?
              beat_cnt_t'((nwords - 1) % `WM_BURST_LEN) : beat_cnt_t'(`WM_BURST_LEN - 1));
  end
  for (int k = 0; k < nwords; k++) begin
    beat = w_q[w_base + k];
    check_data("m_axi_w.data", beat.data, exp_data[k]);
    check_strb("m_axi_w.strb", beat.strb, (k == nwords - 1) ? last_strb : strb_t'(4'hF));
    check_bit("m_axi_w.last", beat.last,
              (k % `WM_BURST_LEN == `WM_BURST_LEN - 1) || (k == nwords - 1));
  end
endtask

////////////////////
// Directed tests
////////////////////
task automatic test_reset_state();
  check_bit("m_axi_awvalid", m_axi_awvalid, 1'b0);
  check_bit("m_axi_wvalid", m_axi_wvalid, 1'b0);
  check_bit("ctrl_done", ctrl_done, 1'b0);
  check_bit("s_axis_tready", s_axis_tready, 1'b1);
  check_bit("m_axi_bready", m_axi_bready, 1'b1);
endtask

// 10 bytes, three beats and a two byte tail
task automatic test_small_transfer();
  w_beat_t beat;
  exp_data.delete();
  for (int i = 1; i <= 3; i++) begin
    exp_data.push_back(data_t'(i));
  end
  run_transfer(32'h0000_1000, 20'd10, 1'b0);
  check_addr("m_axi_aw.addr", aw_q[aw_q.size() - 1].addr, 32'h0000_1000);
  beat = w_q[w_q.size() - 1];
  check_strb("m_axi_w.strb", beat.strb, 4'b0011);
endtask

// Unaligned start, two full bursts and a 138 beat tail
task automatic test_multi_burst();
  exp_data.delete();
  for (int i = 0; i < 650; i++) begin
    exp_data.push_back(32'hA500_0000 + data_t'(i));
  end
  run_transfer(32'h0000_2345, 20'd2600, 1'b0);
  check_len("m_axi_aw.len", aw_q[aw_q.size() - 1].len, 8'd137);
endtask

// Slow slave, stream gaps and responses held until 32 are due
task automatic test_back_pressure();
  exp_data.delete();
  for (int i = 0; i < 40 * `WM_BURST_LEN; i++) begin
    stream_rand = lcg_next(stream_rand);
    exp_data.push_back(stream_rand);
  end
  stress    = 1'b1;
  limit_hit = 1'b0;
  b_hold    = 1'b1;
  run_transfer(32'h0010_0000, xfer_size_t'(40 * `WM_BURST_BYTES - 3), 1'b1);
  stress = 1'b0;
  check_bit("outstanding limit reached", limit_hit, 1'b1);
endtask

task automatic test_done_pulse();
  exp_data.delete();
  exp_data.push_back(32'hDEAD_BEEF);
  run_transfer(32'h0000_8000, 20'd4, 1'b0);
  check_count("ctrl_done cycle", done_cycle, last_b_cycle + 1);
  check_count("ctrl_done pulses", done_cnt, xfer_cnt);
endtask

`endif

/* tests/tb_write_master.sv */
`timescale 1ns/1ps
/*
 * Testbench for the AXI4 write master
 * AXI slave model with random ready and held responses, a watchdog
 * and the directed test sequence
 */
`include "wm_macros.svh"

module tb_write_master;
  import wm_pkg::*;

  // Beats over all tests, 20 cycles each plus a margin
  localparam int total_beats     = 3 + 650 + 40 * `WM_BURST_LEN + 1;
  localparam int watchdog_cycles = 20 * total_beats + 2000;

  logic        aclk           = 1'b0;
  logic        areset         = 1'b1;
  logic        ctrl_start     = 1'b0;
  ctrl_req_t   ctrl_req       = '0;
  logic        ctrl_done;
  logic        s_axis_tvalid  = 1'b0;
  logic        s_axis_tready;
  data_t       s_axis_tdata   = '0;
  logic        m_axi_awvalid;
  logic        m_axi_awready  = 1'b0;
  aw_req_t     m_axi_aw;
  logic        m_axi_wvalid;
  logic        m_axi_wready   = 1'b0;
  w_beat_t     m_axi_w;
  logic        m_axi_bvalid   = 1'b0;
  logic        m_axi_bready;

  // Slave record, totals over the whole run
  aw_req_t     aw_q[$];
  w_beat_t     w_q[$];
  data_t       exp_data[$];
  int          aw_cnt         = 0;
  int          wlast_cnt      = 0;
  int          b_cnt          = 0;
  int          b_target       = 0;
  int          first_seen     = 0;
  int          done_cnt       = 0;
  int          xfer_cnt       = 0;
  int          cycle_cnt      = 0;
  int          last_b_cycle   = 0;
  int          done_cycle     = 0;
  logic        done_due       = 1'b0;
  logic        w_expect_first = 1'b1;
  logic        first_counted  = 1'b0;
  logic        w_wait         = 1'b0;
  w_beat_t     w_prev         = '0;
  logic        aw_wait        = 1'b0;
  aw_req_t     aw_prev        = '0;
  logic        b_hold         = 1'b0;
  logic        limit_hit      = 1'b0;
  logic        stress         = 1'b0;
  logic [31:0] slave_rand     = 32'd29546;
  logic [31:0] stream_rand    = 32'd29546;

  always #4 aclk = ~aclk;

  wm_write_master DUT (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  `include "tb_checks.svh"

  ////////////////////
  // AXI slave model
  ////////////////////
  // Drives on the falling edge, then records what the next rising edge takes
  always @(negedge aclk) begin : slave_model
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    cycle_cnt++;
    slave_rand = lcg_next(slave_rand);
    if (stress) begin
      m_axi_awready = slave_rand[16];
      m_axi_wready  = slave_rand[17];
    end else begin
      m_axi_awready = |slave_rand[17:16];
      m_axi_wready  = |slave_rand[19:18];
    end
    // Answer once address and last beat of a burst are both in
    m_axi_bvalid = !areset && !b_hold && (aw_cnt > b_cnt) && (wlast_cnt > b_cnt);
    if (!areset) begin
      aw_hs = m_axi_awvalid && m_axi_awready;
      w_hs  = m_axi_wvalid && m_axi_wready;
      b_hs  = m_axi_bvalid && m_axi_bready;
      // A waiting beat stays put
      if (w_wait) begin
        check_bit("m_axi_wvalid held", m_axi_wvalid, 1'b1);
        check_data("m_axi_w.data held", m_axi_w.data, w_prev.data);
        check_strb("m_axi_w.strb held", m_axi_w.strb, w_prev.strb);
        check_bit("m_axi_w.last held", m_axi_w.last, w_prev.last);
      end
      w_wait = m_axi_wvalid && !m_axi_wready;
      w_prev = m_axi_w;
      // A waiting address stays put
      if (aw_wait) begin
        check_bit("m_axi_awvalid held", m_axi_awvalid, 1'b1);
        check_addr("m_axi_aw.addr held", m_axi_aw.addr, aw_prev.addr);
        check_len("m_axi_aw.len held", m_axi_aw.len, aw_prev.len);
      end
      aw_wait = m_axi_awvalid && !m_axi_awready;
      aw_prev = m_axi_aw;
      check_bit("ctrl_done", ctrl_done, done_due);
      if (ctrl_done) begin
        done_cnt++;
        done_cycle = cycle_cnt;
      end
      if (m_axi_wvalid && w_expect_first && !first_counted) begin
        first_seen++;
        first_counted = 1'b1;
      end
      if (w_hs) begin
        w_q.push_back(m_axi_w);
        w_expect_first = m_axi_w.last;
        first_counted  = 1'b0;
        if (m_axi_w.last) begin
          wlast_cnt++;
        end
      end
      if (aw_hs) begin
        aw_q.push_back(m_axi_aw);
        aw_cnt++;
        if (aw_cnt > first_seen) begin
          abort_run("AW issued before the first beat of its burst was valid on W");
        end
      end
      if (b_hs) begin
        b_cnt++;
        last_b_cycle = cycle_cnt;
      end
      done_due = b_hs && (b_cnt == b_target);
      if (aw_cnt - b_cnt > `WM_MAX_OUTSTANDING) begin
        abort_run($sformatf("%0d bursts outstanding, above the limit", aw_cnt - b_cnt));
      end
      // Held responses are released once the limit is reached
      if (b_hold && (aw_cnt - b_cnt == `WM_MAX_OUTSTANDING)) begin
        limit_hit = 1'b1;
        b_hold    = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge aclk);
    abort_run($sformatf("watchdog expired after %0d cycles, the run stalled", watchdog_cycles));
  end

  initial begin : test_sequence
    // Reset held for 10 cycles
    repeat (10) @(negedge aclk);
    areset = 1'b0;
    @(negedge aclk);
    test_reset_state();
    test_small_transfer();
    test_multi_burst();
    test_back_pressure();
    test_done_pulse();
    $display("sim passed");
    $finish;
  end

endmodule

/* write_channels/wm_aw_channel.sv */
`timescale 1ns/1ps
/*
 * AXI4 write address channel
 * Watches W for the first beat of each burst and issues one address
 * per first beat, stepping by a full burst, within the credit limit
 */
`include "wm_macros.svh"

module wm_aw_channel (
  input  logic               aclk,
  input  logic               areset,
  input  logic               start,
  input  wm_pkg::xfer_plan_t plan,
  input  logic               m_axi_wvalid,
  input  logic               m_axi_wlast,
  input  logic               m_axi_wready,
  output logic               m_axi_awvalid,
  input  logic               m_axi_awready,
  output wm_pkg::aw_req_t    m_axi_aw,
  input  logic               m_axi_bvalid
);
  import wm_pkg::*;

  localparam addr_t     burst_step = addr_t'(`WM_BURST_BYTES);
  localparam beat_cnt_t full_len   = beat_cnt_t'(`WM_BURST_LEN - 1);

  logic  wxfer;
  logic  awxfer;
  logic  bxfer;
  logic  wfirst;
  logic  first_seen;
  logic  first_beat;
  logic  no_pending;
  logic  final_burst;
  logic  no_credit;
  addr_t addr;

  assign wxfer  = m_axi_wvalid & m_axi_wready;
  assign awxfer = m_axi_awvalid & m_axi_awready;
  // bready is tied high in the response channel
  assign bxfer  = m_axi_bvalid;

  ////////////////////
  // First beat detect
  ////////////////////
  // Counted once even when the beat waits on wready
  assign first_beat = m_axi_wvalid & wfirst & ~first_seen;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst     <= 1'b1;
      first_seen <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= m_axi_wlast;
      end
      if (wxfer) begin
        first_seen <= 1'b0;
      end else if (first_beat) begin
        first_seen <= 1'b1;
      end
    end
  end

  // First beats seen with no address issued yet
  wm_counter #(
    .width ($bits(burst_cnt_t))
  ) u_pending_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (first_beat),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (no_pending)
  );

  // Addresses still to issue after the current one
  wm_counter #(
    .width ($bits(burst_cnt_t))
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (awxfer & ~final_burst),
    .load_value (plan.last_burst),
    .count      (),
    .is_zero    (final_burst)
  );

  // Free slots for bursts awaiting a response
  wm_counter #(
    .width       ($bits(credit_t)),
    .reset_value (credit_t'(`WM_MAX_OUTSTANDING))
  ) u_credit_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bxfer),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (no_credit)
  );

  ////////////////////
  // Address issue
  ////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (!m_axi_awvalid) begin
      m_axi_awvalid <= ~no_pending & ~no_credit;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      addr <= plan.base_addr;
    end else if (awxfer) begin
      addr <= addr + burst_step;
    end
  end

  assign m_axi_aw.addr = addr;
  assign m_axi_aw.len  = final_burst ? plan.final_len : full_len;

  // A waiting address keeps valid and payload until accepted
  a_aw_stable : assert property (@(posedge aclk) disable iff (areset)
    (m_axi_awvalid && !m_axi_awready) |=> (m_axi_awvalid && $stable(m_axi_aw)))
    else $error("wm_aw_channel AW changed while waiting");

endmodule

/* write_channels/wm_b_channel.sv */
`timescale 1ns/1ps
/*
 * AXI4 write response channel
 * Counts responses and pulses done after the final one
 */
module wm_b_channel (
  input  logic               aclk,
  input  logic               areset,
  input  logic               start,
  input  wm_pkg::xfer_plan_t plan,
  input  logic               m_axi_bvalid,
  output logic               m_axi_bready,
  output logic               ctrl_done
);
  import wm_pkg::*;

  logic bxfer;
  logic final_resp;

  // Responses are always accepted
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;

  // Responses still due after the next one
  wm_counter #(
    .width ($bits(burst_cnt_t))
  ) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (bxfer & ~final_resp),
    .load_value (plan.last_burst),
    .count      (),
    .is_zero    (final_resp)
  );

  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= bxfer & final_resp;
    end
  end

endmodule

/* write_channels/wm_w_channel.sv */
`timescale 1ns/1ps
/*
 * AXI4 write data channel
 * Passes FIFO words onto W while running, counts beats and bursts
 * to place WLAST and the partial strobe of the final beat
 */
`include "wm_macros.svh"

module wm_w_channel (
  input  logic               aclk,
  input  logic               areset,
  input  logic               start,
  input  wm_pkg::xfer_plan_t plan,
  input  logic               fifo_valid,
  input  wm_pkg::data_t      fifo_data,
  output logic               fifo_pop,
  output logic               m_axi_wvalid,
  input  logic               m_axi_wready,
  output wm_pkg::w_beat_t    m_axi_w
);
  import wm_pkg::*;

  localparam beat_cnt_t full_len = beat_cnt_t'(`WM_BURST_LEN - 1);

  logic       running;
  logic       wxfer;
  logic       beat_last;
  logic       final_burst;
  logic       final_transfer;
  logic       next_is_final;
  logic       beat_load;
  beat_cnt_t  beat_load_value;
  burst_cnt_t bursts_left;

  // Nothing leaves the FIFO before the plan is known
  assign m_axi_wvalid   = fifo_valid & running;
  assign wxfer          = m_axi_wvalid & m_axi_wready;
  assign fifo_pop       = wxfer;
  assign final_transfer = wxfer & beat_last & final_burst;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_transfer) begin
      running <= 1'b0;
    end
  end

  ////////////////////
  // Beat counting
  ////////////////////
  // At start the first burst is the final one when only one is planned
  assign next_is_final   = start ? (plan.last_burst == '0) : (bursts_left == burst_cnt_t'(1));
  assign beat_load       = start | (wxfer & beat_last);
  assign beat_load_value = next_is_final ? plan.final_len : full_len;

  // Beats left in the current burst, zero marks WLAST
  wm_counter #(
    .width       ($bits(beat_cnt_t)),
    .reset_value (full_len)
  ) u_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (beat_load),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (beat_load_value),
    .count      (),
    .is_zero    (beat_last)
  );

  // Bursts left after the current one
  wm_counter #(
    .width ($bits(burst_cnt_t))
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (wxfer & beat_last & ~final_burst),
    .load_value (plan.last_burst),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  assign m_axi_w.data = fifo_data;
  // Partial strobe only on the very last beat
  assign m_axi_w.strb = (beat_last & final_burst) ? plan.final_strb : '1;
  assign m_axi_w.last = beat_last;

endmodule
